/* logic/ahb_pkg.sv */
package ahb_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // Byte address on the AHB bus.
    typedef logic [ADDR_W-1:0] addr_t;

    // One read data word.
    typedef logic [DATA_W-1:0] data_t;

    // HTRANS codes.
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

    // HBURST codes, only the kinds this engine issues.
    typedef enum logic [2:0] {
        SINGLE = 3'b000,
        WRAP4  = 3'b010,
        INCR4  = 3'b011
    } hburst_t;

endpackage

/* logic/burst_cfg_pkg.sv */
package burst_cfg_pkg;

    // Number of burst sequencers.
    localparam int NUM_CHAN = 4;
    localparam int CHAN_W = $clog2(NUM_CHAN);

    typedef logic [CHAN_W-1:0] chan_t;
    typedef logic [NUM_CHAN-1:0] chan_mask_t;

    // Keeps the 16-byte block base of an address.
    localparam logic [31:0] WRAP4_MASK = 32'hffff_fff0;

    // Address step of one word beat.
    localparam int BEAT_BYTES = 4;

    typedef logic [1:0] beat_cnt_t;

    // Index of the last beat of a four-beat burst.
    localparam beat_cnt_t LAST_BEAT4 = 2'd3;

endpackage

/* logic/cmd_dispatch.sv */
`timescale 1ns/1ps

module cmd_dispatch (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      cmd_valid,
    input  ahb_pkg::addr_t            cmd_addr,
    input  ahb_pkg::hburst_t          cmd_burst,
    input  burst_cfg_pkg::chan_mask_t done,
    output logic                      cmd_ready,
    output burst_cfg_pkg::chan_mask_t start,
    output ahb_pkg::addr_t            start_addr,
    output ahb_pkg::hburst_t          start_burst
);

    burst_cfg_pkg::chan_mask_t busy_q;
    burst_cfg_pkg::chan_mask_t free_mask;
    burst_cfg_pkg::chan_mask_t pick_mask;
    logic                      take;

    assign free_mask = ~busy_q;

    // Lowest set bit of the idle mask.
    assign pick_mask = free_mask & (~free_mask + 1'b1);

    assign cmd_ready = |free_mask;
    assign take      = cmd_valid & cmd_ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy_q <= '0;
            start  <= '0;
        end else begin
            busy_q <= (busy_q & ~done) | (take ? pick_mask : '0);
            start  <= take ? pick_mask : '0;
        end
    end

    // Command payload, sampled with the start strobe.
    always_ff @(posedge clk) begin
        if (take) begin
            start_addr  <= cmd_addr;
            start_burst <= cmd_burst;
        end
    end

    a_start_onehot: assert property (
        @(posedge clk) disable iff (!rstn)
        $onehot0(start)
    );

    a_done_busy: assert property (
        @(posedge clk) disable iff (!rstn)
        (done & ~busy_q) == '0
    );

endmodule

/* logic/burst_sequencer.sv */
`timescale 1ns/1ps

module burst_sequencer (
    input  logic             clk,
    input  logic             rstn,
    input  logic             start,
    input  ahb_pkg::addr_t   start_addr,
    input  ahb_pkg::hburst_t start_burst,
    input  logic             beat_ack,
    output logic             req,
    output ahb_pkg::addr_t   haddr,
    output ahb_pkg::htrans_t htrans,
    output ahb_pkg::hburst_t hburst,
    output logic             done
);

    typedef enum logic {
        IDLE,
        ISSUE
    } state_t;

    state_t                    state_q;
    burst_cfg_pkg::beat_cnt_t  cnt_q;
    ahb_pkg::addr_t            base_q;
    ahb_pkg::addr_t            offset_q;
    ahb_pkg::hburst_t          burst_q;

    logic                      last_beat;
    ahb_pkg::addr_t            offset_inc;
    ahb_pkg::addr_t            offset_next;

    assign req    = (state_q == ISSUE);
    assign haddr  = base_q + offset_q;
    assign hburst = burst_q;

    // First beat of a burst opens with NONSEQ.
    always_comb begin
        if (!req) begin
            htrans = ahb_pkg::IDLE;
        end else if (cnt_q == '0) begin
            htrans = ahb_pkg::NONSEQ;
        end else begin
            htrans = ahb_pkg::SEQ;
        end
    end

    assign last_beat = (burst_q == ahb_pkg::SINGLE) ||
                       (cnt_q == burst_cfg_pkg::LAST_BEAT4);

    assign done = req && beat_ack && last_beat;

    assign offset_inc = offset_q + ahb_pkg::addr_t'(burst_cfg_pkg::BEAT_BYTES);

    // WRAP4 folds the offset back into the 16-byte block.
    always_comb begin
        if (burst_q == ahb_pkg::WRAP4) begin
            offset_next = offset_inc & ~burst_cfg_pkg::WRAP4_MASK;
        end else begin
            offset_next = offset_inc;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start) begin
                        state_q <= ISSUE;
                        cnt_q   <= '0;
                    end
                end
                ISSUE: begin
                    if (beat_ack) begin
                        if (last_beat) begin
                            state_q <= IDLE;
                        end
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // Address registers are visible on the bus, so they start clean.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            base_q   <= '0;
            offset_q <= '0;
            burst_q  <= ahb_pkg::SINGLE;
        end else if (start && state_q == IDLE) begin
            base_q   <= start_addr & burst_cfg_pkg::WRAP4_MASK;
            offset_q <= start_addr & ~burst_cfg_pkg::WRAP4_MASK;
            burst_q  <= start_burst;
        end else if (beat_ack && !last_beat) begin
            offset_q <= offset_next;
        end
    end

    a_no_start_busy: assert property (
        @(posedge clk) disable iff (!rstn)
        start |-> state_q == IDLE
    );

    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (!rstn)
        beat_ack |-> req
    );

endmodule

/* logic/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter (
    input  logic                      clk,
    input  logic                      rstn,
    input  burst_cfg_pkg::chan_mask_t req,
    input  ahb_pkg::addr_t            seq_haddr  [burst_cfg_pkg::NUM_CHAN],
    input  ahb_pkg::htrans_t          seq_htrans [burst_cfg_pkg::NUM_CHAN],
    input  ahb_pkg::hburst_t          seq_hburst [burst_cfg_pkg::NUM_CHAN],
    input  burst_cfg_pkg::chan_mask_t done,
    input  logic                      hready,
    input  ahb_pkg::data_t            hrdata,
    output burst_cfg_pkg::chan_mask_t beat_ack,
    output ahb_pkg::addr_t            haddr,
    output ahb_pkg::htrans_t          htrans,
    output ahb_pkg::hburst_t          hburst,
    output logic                      rd_valid,
    output ahb_pkg::addr_t            rd_addr,
    output ahb_pkg::data_t            rd_data,
    output burst_cfg_pkg::chan_t      rd_chan
);

    typedef enum logic {
        FREE,
        OWNED
    } state_t;

    state_t                    state_q;
    burst_cfg_pkg::chan_mask_t grant_q;
    burst_cfg_pkg::chan_t      owner_q;
    burst_cfg_pkg::chan_mask_t cand;
    burst_cfg_pkg::chan_t      pick;
    logic                      found;
    logic                      burst_end;

    logic                      dp_valid;
    ahb_pkg::addr_t            dp_addr;
    burst_cfg_pkg::chan_t      dp_chan;

    assign burst_end = (state_q == OWNED) && ((done & grant_q) != '0);

    // The current owner is excluded while it finishes.
    assign cand = req & ~grant_q;

    // Round-robin search starting after the last owner.
    always_comb begin : rr_pick
        burst_cfg_pkg::chan_t idx;
        found = 1'b0;
        pick  = '0;
        for (int k = 1; k <= burst_cfg_pkg::NUM_CHAN; k++) begin
            idx = burst_cfg_pkg::chan_t'(owner_q + k);
            if (!found && cand[idx]) begin
                found = 1'b1;
                pick  = idx;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q <= FREE;
            grant_q <= '0;
            owner_q <= burst_cfg_pkg::chan_t'(burst_cfg_pkg::NUM_CHAN - 1);
        end else if ((state_q == FREE || burst_end) && found) begin
            state_q <= OWNED;
            grant_q <= burst_cfg_pkg::chan_mask_t'(1) << pick;
            owner_q <= pick;
        end else if (burst_end) begin
            state_q <= FREE;
            grant_q <= '0;
        end
    end

    assign beat_ack = hready ? grant_q : '0;

    assign haddr  = seq_haddr[owner_q];
    assign hburst = seq_hburst[owner_q];
    assign htrans = (state_q == OWNED) ? seq_htrans[owner_q] : ahb_pkg::IDLE;

    // Data phase follows each accepted address phase.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            dp_valid <= 1'b0;
            rd_valid <= 1'b0;
        end else if (hready) begin
            dp_valid <= (state_q == OWNED);
            rd_valid <= dp_valid;
        end else begin
            rd_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (hready) begin
            dp_addr <= haddr;
            dp_chan <= owner_q;
            if (dp_valid) begin
                rd_addr <= dp_addr;
                rd_data <= hrdata;
                rd_chan <= dp_chan;
            end
        end
    end

    a_grant_onehot: assert property (
        @(posedge clk) disable iff (!rstn)
        $onehot0(grant_q) && ((grant_q & ~req) == '0)
    );

    a_idle_when_free: assert property (
        @(posedge clk) disable iff (!rstn)
        (state_q == FREE) == (htrans == ahb_pkg::IDLE)
    );

endmodule

/* logic/ahb_burst_top.sv */
`timescale 1ns/1ps

module ahb_burst_top (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 cmd_valid,
    input  ahb_pkg::addr_t       cmd_addr,
    input  ahb_pkg::hburst_t     cmd_burst,
    output logic                 cmd_ready,
    output ahb_pkg::addr_t       haddr,
    output ahb_pkg::htrans_t     htrans,
    output ahb_pkg::hburst_t     hburst,
    input  logic                 hready,
    input  ahb_pkg::data_t       hrdata,
    output logic                 rd_valid,
    output ahb_pkg::addr_t       rd_addr,
    output ahb_pkg::data_t       rd_data,
    output burst_cfg_pkg::chan_t rd_chan
);

    burst_cfg_pkg::chan_mask_t start;
    burst_cfg_pkg::chan_mask_t done;
    burst_cfg_pkg::chan_mask_t req;
    burst_cfg_pkg::chan_mask_t beat_ack;
    ahb_pkg::addr_t            start_addr;
    ahb_pkg::hburst_t          start_burst;
    ahb_pkg::addr_t            seq_haddr  [burst_cfg_pkg::NUM_CHAN];
    ahb_pkg::htrans_t          seq_htrans [burst_cfg_pkg::NUM_CHAN];
    ahb_pkg::hburst_t          seq_hburst [burst_cfg_pkg::NUM_CHAN];

    cmd_dispatch u_dispatch (
        .clk         (clk),
        .rstn        (rstn),
        .cmd_valid   (cmd_valid),
        .cmd_addr    (cmd_addr),
        .cmd_burst   (cmd_burst),
        .done        (done),
        .cmd_ready   (cmd_ready),
        .start       (start),
        .start_addr  (start_addr),
        .start_burst (start_burst)
    );

    for (genvar i = 0; i < burst_cfg_pkg::NUM_CHAN; i++) begin : g_seq
        burst_sequencer u_seq (
            .clk         (clk),
            .rstn        (rstn),
            .start       (start[i]),
            .start_addr  (start_addr),
            .start_burst (start_burst),
            .beat_ack    (beat_ack[i]),
            .req         (req[i]),
            .haddr       (seq_haddr[i]),
            .htrans      (seq_htrans[i]),
            .hburst      (seq_hburst[i]),
            .done        (done[i])
        );
    end

    bus_arbiter u_arbiter (
        .clk        (clk),
        .rstn       (rstn),
        .req        (req),
        .seq_haddr  (seq_haddr),
        .seq_htrans (seq_htrans),
        .seq_hburst (seq_hburst),
        .done       (done),
        .hready     (hready),
        .hrdata     (hrdata),
        .beat_ack   (beat_ack),
        .haddr      (haddr),
        .htrans     (htrans),
        .hburst     (hburst),
        .rd_valid   (rd_valid),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .rd_chan    (rd_chan)
    );

endmodule

/* verif/ahb_slave_model.sv */
`timescale 1ns/1ps

module ahb_slave_model #(
    parameter logic [31:0] SEED     = 32'h1,
    parameter logic [31:0] DATA_KEY = 32'h0
) (
    input  logic             clk,
    input  logic             wait_en,
    input  ahb_pkg::addr_t   haddr,
    input  ahb_pkg::htrans_t htrans,
    output logic             hready,
    output ahb_pkg::data_t   hrdata
);

    logic [31:0]    rng;
    logic           take;
    logic           stall;
    ahb_pkg::addr_t next_addr;
    ahb_pkg::addr_t dp_addr;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Read data is a fixed function of the data-phase address.
    assign hrdata = dp_addr ^ DATA_KEY;

    initial begin
        rng     = SEED;
        hready  = 1'b1;
        dp_addr = '0;
    end

    // Sample the address phase at the edge, drive the response a bit later.
    always @(posedge clk) begin
        take      = hready && (htrans == ahb_pkg::NONSEQ || htrans == ahb_pkg::SEQ);
        next_addr = haddr;
        rng       = xorshift32(rng);
        stall     = wait_en && (rng[1:0] == 2'b00);
        #10;
        if (take) begin
            dp_addr = next_addr;
        end
        hready = !stall;
    end

endmodule

/* verif/tb_ahb_burst.sv */
`timescale 1ns/1ps

module tb_ahb_burst;

    localparam int          CLK_PERIOD = 100;
    localparam logic [31:0] SEED       = 32'he9d0;
    localparam logic [31:0] DATA_KEY   = 32'h5a5a_0000;

    // Test lengths in beats.
    localparam int LEN_RESET  = 8;
    localparam int LEN_SINGLE = 3;
    localparam int LEN_INCR4  = 12;
    localparam int LEN_WRAP4  = 16;
    localparam int LEN_MULTI  = 16;
    localparam int LEN_ALL    = LEN_RESET + LEN_SINGLE +
                                2 * (LEN_INCR4 + LEN_WRAP4 + LEN_MULTI);

    logic                 clk;
    logic                 rstn;
    logic                 cmd_valid;
    ahb_pkg::addr_t       cmd_addr;
    ahb_pkg::hburst_t     cmd_burst;
    logic                 cmd_ready;
    ahb_pkg::addr_t       haddr;
    ahb_pkg::htrans_t     htrans;
    ahb_pkg::hburst_t     hburst;
    logic                 hready;
    ahb_pkg::data_t       hrdata;
    logic                 rd_valid;
    ahb_pkg::addr_t       rd_addr;
    ahb_pkg::data_t       rd_data;
    burst_cfg_pkg::chan_t rd_chan;
    logic                 wait_en;

    // Collected results and the commands that should explain them.
    ahb_pkg::addr_t       q_addr[$];
    ahb_pkg::data_t       q_data[$];
    burst_cfg_pkg::chan_t q_chan[$];
    ahb_pkg::addr_t       exp_start[$];
    ahb_pkg::hburst_t     exp_burst[$];

    // Accepted address phases, in bus order.
    ahb_pkg::addr_t       ap_addr[$];
    ahb_pkg::htrans_t     ap_trans[$];
    ahb_pkg::hburst_t     ap_burst[$];

    ahb_burst_top uut (
        .clk       (clk),
        .rstn      (rstn),
        .cmd_valid (cmd_valid),
        .cmd_addr  (cmd_addr),
        .cmd_burst (cmd_burst),
        .cmd_ready (cmd_ready),
        .haddr     (haddr),
        .htrans    (htrans),
        .hburst    (hburst),
        .hready    (hready),
        .hrdata    (hrdata),
        .rd_valid  (rd_valid),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .rd_chan   (rd_chan)
    );

    ahb_slave_model #(
        .SEED     (SEED),
        .DATA_KEY (DATA_KEY)
    ) u_slave (
        .clk     (clk),
        .wait_en (wait_en),
        .haddr   (haddr),
        .htrans  (htrans),
        .hready  (hready),
        .hrdata  (hrdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        if (rstn && rd_valid === 1'b1) begin
            q_addr.push_back(rd_addr);
            q_data.push_back(rd_data);
            q_chan.push_back(rd_chan);
        end
    end

    always @(posedge clk) begin
        if (rstn && hready === 1'b1 &&
            (htrans === ahb_pkg::NONSEQ || htrans === ahb_pkg::SEQ)) begin
            ap_addr.push_back(haddr);
            ap_trans.push_back(htrans);
            ap_burst.push_back(hburst);
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_addr(input string name, input ahb_pkg::addr_t exp,
                              input ahb_pkg::addr_t act);
        if (act !== exp) begin
            abort_run($sformatf("FAILED %s expected %h got %h", name, exp, act));
        end
    endtask

    task automatic check_data(input string name, input ahb_pkg::data_t exp,
                              input ahb_pkg::data_t act);
        if (act !== exp) begin
            abort_run($sformatf("FAILED %s expected %h got %h", name, exp, act));
        end
    endtask

    task automatic check_chan(input string name, input burst_cfg_pkg::chan_t exp,
                              input burst_cfg_pkg::chan_t act);
        if (act !== exp) begin
            abort_run($sformatf("FAILED %s expected %h got %h", name, exp, act));
        end
    endtask

    task automatic check_htrans(input string name, input ahb_pkg::htrans_t exp,
                                input ahb_pkg::htrans_t act);
        if (act !== exp) begin
            abort_run($sformatf("FAILED %s expected %h got %h", name, exp, act));
        end
    endtask

    task automatic check_burst(input string name, input ahb_pkg::hburst_t exp,
                               input ahb_pkg::hburst_t act);
        if (act !== exp) begin
            abort_run($sformatf("FAILED %s expected %h got %h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("FAILED %s expected %h got %h", name, exp, act));
        end
    endtask

    function automatic int beat_count(input ahb_pkg::hburst_t burst);
        return (burst == ahb_pkg::SINGLE) ? 1 : 4;
    endfunction

    // Address of beat k, wrapping inside the 16-byte block for WRAP4.
    function automatic ahb_pkg::addr_t beat_addr(input ahb_pkg::addr_t start,
                                                 input ahb_pkg::hburst_t burst,
                                                 input int k);
        ahb_pkg::addr_t step;
        step = start + ahb_pkg::addr_t'(4 * k);
        if (burst == ahb_pkg::WRAP4) begin
            return (start & burst_cfg_pkg::WRAP4_MASK) | (step & ~burst_cfg_pkg::WRAP4_MASK);
        end
        return step;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic send_cmd(input ahb_pkg::addr_t addr, input ahb_pkg::hburst_t burst);
        while (cmd_ready !== 1'b1) begin
            next_cycle();
        end
        cmd_valid = 1'b1;
        cmd_addr  = addr;
        cmd_burst = burst;
        exp_start.push_back(addr);
        exp_burst.push_back(burst);
        next_cycle();
        cmd_valid = 1'b0;
    endtask

    // Commands issued from idle land on channels 0 upward in order.
    task automatic finish_cmds();
        int                   total;
        int                   k;
        int                   n;
        int                   i;
        burst_cfg_pkg::chan_t ch;
        ahb_pkg::addr_t       exp_addr;
        ahb_pkg::htrans_t     exp_trans;
        total = 0;
        foreach (exp_burst[c]) begin
            total += beat_count(exp_burst[c]);
        end
        while (q_addr.size() < total) begin
            next_cycle();
        end
        // Give a stray extra beat time to show up.
        repeat (8) begin
            next_cycle();
        end
        if (q_addr.size() != total) begin
            abort_run($sformatf("Expected %0d read results but %0d arrived",
                                total, q_addr.size()));
        end
        if (ap_addr.size() != total) begin
            abort_run($sformatf("Expected %0d address phases but %0d were accepted",
                                total, ap_addr.size()));
        end
        foreach (exp_start[c]) begin
            k = 0;
            foreach (q_addr[j]) begin
                if (q_chan[j] == c) begin
                    exp_addr = beat_addr(exp_start[c], exp_burst[c], k);
                    if (k == 0) begin
                        exp_trans = ahb_pkg::NONSEQ;
                    end else begin
                        exp_trans = ahb_pkg::SEQ;
                    end
                    check_addr("rd_addr", exp_addr, q_addr[j]);
                    check_data("rd_data", exp_addr ^ DATA_KEY, q_data[j]);
                    check_addr("haddr", exp_addr, ap_addr[j]);
                    check_htrans("htrans", exp_trans, ap_trans[j]);
                    check_burst("hburst", exp_burst[c], ap_burst[j]);
                    k++;
                end
            end
            if (k != beat_count(exp_burst[c])) begin
                abort_run($sformatf("Channel %0d returned %0d beats instead of %0d",
                                    c, k, beat_count(exp_burst[c])));
            end
        end
        // Each burst is one unbroken run of its channel.
        i = 0;
        while (i < q_chan.size()) begin
            ch = q_chan[i];
            n  = beat_count(exp_burst[ch]);
            for (int j = 1; j < n; j++) begin
                check_chan("rd_chan", ch, q_chan[i + j]);
            end
            i += n;
        end
        q_addr.delete();
        q_data.delete();
        q_chan.delete();
        ap_addr.delete();
        ap_trans.delete();
        ap_burst.delete();
        exp_start.delete();
        exp_burst.delete();
    endtask

    task automatic test_reset();
        check_htrans("htrans", ahb_pkg::IDLE, htrans);
        check_flag("rd_valid", 1'b0, rd_valid);
        check_flag("cmd_ready", 1'b1, cmd_ready);
    endtask

    task automatic test_single();
        send_cmd(32'h0000_0100, ahb_pkg::SINGLE);
        finish_cmds();
        send_cmd(32'h0000_2004, ahb_pkg::SINGLE);
        finish_cmds();
        send_cmd(32'h0000_abc8, ahb_pkg::SINGLE);
        finish_cmds();
    endtask

    task automatic test_incr4();
        send_cmd(32'h0000_0000, ahb_pkg::INCR4);
        finish_cmds();
        send_cmd(32'h0000_1004, ahb_pkg::INCR4);
        finish_cmds();
        send_cmd(32'h0000_5018, ahb_pkg::INCR4);
        finish_cmds();
    endtask

    task automatic test_wrap4();
        for (int k = 0; k < 4; k++) begin
            send_cmd(ahb_pkg::addr_t'(32'h0000_8020 + 32'h100 * k + 4 * k), ahb_pkg::WRAP4);
            finish_cmds();
        end
    endtask

    task automatic test_four_cmds();
        send_cmd(32'h0000_1000, ahb_pkg::INCR4);
        send_cmd(32'h0000_2008, ahb_pkg::WRAP4);
        send_cmd(32'h0000_3010, ahb_pkg::INCR4);
        send_cmd(32'h0000_400c, ahb_pkg::WRAP4);
        check_flag("cmd_ready", 1'b0, cmd_ready);
        finish_cmds();
    endtask

    initial begin
        #(LEN_ALL * 20 * CLK_PERIOD);
        abort_run("Timeout: the tests did not finish in the allowed time");
    end

    initial begin
        clk       = 1'b0;
        rstn      = 1'b0;
        cmd_valid = 1'b0;
        cmd_addr  = '0;
        cmd_burst = ahb_pkg::SINGLE;
        wait_en   = 1'b0;
        repeat (8) begin
            @(posedge clk);
        end
        #10;
        rstn = 1'b1;
        test_reset();
        test_single();
        test_incr4();
        test_wrap4();
        test_four_cmds();
        // Same traffic again with slave wait states.
        wait_en = 1'b1;
        test_incr4();
        test_wrap4();
        test_four_cmds();
        $display("TEST PASSED");
        $finish;
    end

endmodule

/* ahb_burst.f */
logic/ahb_pkg.sv
logic/burst_cfg_pkg.sv
logic/cmd_dispatch.sv
logic/burst_sequencer.sv
logic/bus_arbiter.sv
logic/ahb_burst_top.sv
verif/ahb_slave_model.sv
verif/tb_ahb_burst.sv
